// ==== hw/rv_pkg.sv ====
// RV32I multicycle core shared definitions
// opcodes, ALU functions, datapath selects and the control/status structs
package rv_pkg;

    localparam int xlen = 32;
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

    typedef enum logic [6:0] {
        opcode_lui    = 7'b0110111,
        opcode_auipc  = 7'b0010111,
        opcode_jal    = 7'b1101111,
        opcode_jalr   = 7'b1100111,
        opcode_branch = 7'b1100011,
        opcode_load   = 7'b0000011,
        opcode_store  = 7'b0100011,
        opcode_op_imm = 7'b0010011,
        opcode_op     = 7'b0110011,
        opcode_system = 7'b1110011
    } opcode_e;

    // branch compares give zero when the condition holds
    typedef enum logic [4:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and,
        alu_eq, alu_ne, alu_lt, alu_ge, alu_ltu, alu_geu
    } alu_fn_e;

    typedef enum logic [1:0] {
        opa_rs1, opa_pc, opa_last_pc
    } opa_sel_e;

    typedef enum logic [1:0] {
        opb_rs2, opb_imm, opb_four
    } opb_sel_e;

    typedef enum logic [1:0] {
        wb_alu_out, wb_data, wb_pc, wb_imm
    } wb_sel_e;

    typedef struct packed {
        alu_fn_e  alu_fn;
        opa_sel_e opa_sel;
        opb_sel_e opb_sel;
        logic     next_pc_sel;  // 0 alu result, bit 0 cleared; 1 alu_out
        logic     pc_we;
        logic     last_pc_we;
        logic     alu_out_we;
        logic     inst_we;
        logic     data_we;
        logic     rf_we;
        wb_sel_e  wb_sel;
        logic     addr_sel;     // 0 pc, 1 alu_out
    } dp_ctrl_t;

    typedef struct packed {
        logic [6:0] opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        logic       alu_zero;
    } inst_fields_t;

endpackage

// ==== hw/rv_decode.sv ====
// RV32I instruction decoder
// register fields plus the sign-extended immediate of the instruction's format
`timescale 1ns/1ps

module rv_decode (
    input  logic [rv_pkg::xlen-1:0] inst,
    output rv_pkg::inst_fields_t    fields,
    output logic [4:0]              rd,
    output logic [4:0]              rs1,
    output logic [4:0]              rs2,
    output logic [rv_pkg::xlen-1:0] immediate
);
    import rv_pkg::*;

    always_comb begin
        fields.opcode = inst[6:0];
        fields.funct3 = inst[14:12];
        fields.funct7 = inst[31:25];
        // zero flag comes from the alu, merged in the datapath
        fields.alu_zero = 1'b0;
    end

    assign rd  = inst[11:7];
    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];

    always_comb begin
        case (inst[6:0])
            opcode_store:
                immediate = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            opcode_branch:
                immediate = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                             inst[11:8], 1'b0};
            opcode_lui,
            opcode_auipc:
                immediate = {inst[31:12], 12'b0};
            opcode_jal:
                immediate = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                             inst[30:21], 1'b0};
            // I-type for op_imm, load, jalr and system
            default:
                immediate = {{20{inst[31]}}, inst[31:20]};
        endcase
    end

endmodule

// ==== hw/rv_alu.sv ====
// RV32I ALU
// arithmetic, logic, shifts, set-less-than and branch compares
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::alu_fn_e         alu_fn,
    input  logic [rv_pkg::xlen-1:0] operand_a,
    input  logic [rv_pkg::xlen-1:0] operand_b,
    output logic [rv_pkg::xlen-1:0] result,
    output logic                    result_equal_zero
);
    import rv_pkg::*;

    logic [4:0] shamt;
    logic       less_signed;
    logic       less_unsigned;
    logic       equal;

    assign shamt         = operand_b[4:0];
    assign less_signed   = $signed(operand_a) < $signed(operand_b);
    assign less_unsigned = operand_a < operand_b;
    assign equal         = operand_a == operand_b;

    always_comb begin
        case (alu_fn)
            alu_add:  result = operand_a + operand_b;
            alu_sub:  result = operand_a - operand_b;
            alu_sll:  result = operand_a << shamt;
            alu_slt:  result = {{(xlen-1){1'b0}}, less_signed};
            alu_sltu: result = {{(xlen-1){1'b0}}, less_unsigned};
            alu_xor:  result = operand_a ^ operand_b;
            alu_srl:  result = operand_a >> shamt;
            alu_sra:  result = $unsigned($signed(operand_a) >>> shamt);
            alu_or:   result = operand_a | operand_b;
            alu_and:  result = operand_a & operand_b;
            // compares: a zero result means the branch is taken
            alu_eq:   result = {{(xlen-1){1'b0}}, ~equal};
            alu_ne:   result = {{(xlen-1){1'b0}}, equal};
            alu_lt:   result = {{(xlen-1){1'b0}}, ~less_signed};
            alu_ge:   result = {{(xlen-1){1'b0}}, less_signed};
            alu_ltu:  result = {{(xlen-1){1'b0}}, ~less_unsigned};
            alu_geu:  result = {{(xlen-1){1'b0}}, less_unsigned};
            default:  result = '0;
        endcase
    end

    assign result_equal_zero = (result == '0);

endmodule

// ==== hw/rv_regfile.sv ====
// RV32I register file, 32 x 32
// x0 reads zero, two asynchronous read ports, one synchronous write port
`timescale 1ns/1ps

module rv_regfile (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    write_enable,
    input  logic [4:0]              rd_address,
    input  logic [4:0]              rs1_address,
    input  logic [4:0]              rs2_address,
    input  logic [rv_pkg::xlen-1:0] rd_data,
    output logic [rv_pkg::xlen-1:0] rs1_data,
    output logic [rv_pkg::xlen-1:0] rs2_data
);

    logic [rv_pkg::xlen-1:0] regs [0:31];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && rd_address != 5'd0) begin
            regs[rd_address] <= rd_data;
        end
    end

    assign rs1_data = (rs1_address == 5'd0) ? '0 : regs[rs1_address];
    assign rs2_data = (rs2_address == 5'd0) ? '0 : regs[rs2_address];

endmodule

// ==== hw/multicycle_datapath.sv ====
// RV32I multicycle datapath
// pc, instruction, data and operand registers around one shared ALU
`timescale 1ns/1ps

module multicycle_datapath (
    input  logic                    clock,
    input  logic                    arst_n,
    input  rv_pkg::dp_ctrl_t        ctrl,
    input  logic [rv_pkg::xlen-1:0] mem_read_data,
    output logic [rv_pkg::xlen-1:0] mem_address,
    output logic [rv_pkg::xlen-1:0] mem_write_data,
    output rv_pkg::inst_fields_t    status,
    output logic [rv_pkg::xlen-1:0] pc
);
    import rv_pkg::*;

    logic [xlen-1:0] last_pc;
    logic [xlen-1:0] inst;
    logic [xlen-1:0] data;
    logic [xlen-1:0] alu_out;
    logic [xlen-1:0] rs1_q;
    logic [xlen-1:0] rs2_q;

    inst_fields_t    dec_fields;
    logic [4:0]      rd_address;
    logic [4:0]      rs1_address;
    logic [4:0]      rs2_address;
    logic [xlen-1:0] immediate;

    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] rd_data;

    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_result;
    logic            alu_zero;
    logic [xlen-1:0] next_pc;

    rv_decode decode0 (
        .inst      (inst),
        .fields    (dec_fields),
        .rd        (rd_address),
        .rs1       (rs1_address),
        .rs2       (rs2_address),
        .immediate (immediate)
    );

    rv_alu alu0 (
        .alu_fn            (ctrl.alu_fn),
        .operand_a         (alu_a),
        .operand_b         (alu_b),
        .result            (alu_result),
        .result_equal_zero (alu_zero)
    );

    rv_regfile regfile0 (
        .clock        (clock),
        .arst_n       (arst_n),
        .write_enable (ctrl.rf_we),
        .rd_address   (rd_address),
        .rs1_address  (rs1_address),
        .rs2_address  (rs2_address),
        .rd_data      (rd_data),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data)
    );

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc      <= reset_pc;
            last_pc <= reset_pc;
        end else begin
            if (ctrl.pc_we) begin
                pc <= next_pc;
            end
            if (ctrl.last_pc_we) begin
                last_pc <= pc;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (ctrl.inst_we) begin
            inst <= mem_read_data;
        end
        if (ctrl.data_we) begin
            data <= mem_read_data;
        end
        if (ctrl.alu_out_we) begin
            alu_out <= alu_result;
        end
        // operands follow the decoded register numbers every cycle
        rs1_q <= rs1_data;
        rs2_q <= rs2_data;
    end

    always_comb begin
        case (ctrl.opa_sel)
            opa_rs1:     alu_a = rs1_q;
            opa_pc:      alu_a = pc;
            opa_last_pc: alu_a = last_pc;
            default:     alu_a = '0;
        endcase
    end

    always_comb begin
        case (ctrl.opb_sel)
            opb_rs2:  alu_b = rs2_q;
            opb_imm:  alu_b = immediate;
            opb_four: alu_b = xlen'(4);
            default:  alu_b = '0;
        endcase
    end

    always_comb begin
        case (ctrl.wb_sel)
            wb_alu_out: rd_data = alu_out;
            wb_data:    rd_data = data;
            wb_pc:      rd_data = pc;
            default:    rd_data = immediate;
        endcase
    end

    // jalr target needs bit 0 cleared, branch and jal targets sit in alu_out
    assign next_pc = ctrl.next_pc_sel ? alu_out : {alu_result[xlen-1:1], 1'b0};

    assign mem_address    = ctrl.addr_sel ? alu_out : pc;
    assign mem_write_data = rs2_q;

    always_comb begin
        status          = dec_fields;
        status.alu_zero = alu_zero;
    end

    a_pc_aligned: assert property (
        @(posedge clock) disable iff (!arst_n) pc[1:0] == 2'b00
    ) else $error("pc lost word alignment: %h", pc);

endmodule

// ==== hw/multicycle_control.sv ====
// RV32I multicycle control
// steps the datapath through fetch, decode, execute, memory and writeback
`timescale 1ns/1ps

module multicycle_control (
    input  logic                 clock,
    input  logic                 arst_n,
    input  rv_pkg::inst_fields_t status,
    output rv_pkg::dp_ctrl_t     ctrl,
    output logic                 mem_write,
    output logic                 halt
);
    import rv_pkg::*;

    typedef enum logic [3:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_mem_addr,
        st_mem_read,
        st_mem_write,
        st_writeback,
        st_branch,
        st_halt
    } state_e;

    state_e  state;
    state_e  next_state;
    alu_fn_e op_fn;
    alu_fn_e branch_fn;
    logic    is_op;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_fetch;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_fetch:  next_state = st_decode;
            st_decode: begin
                case (status.opcode)
                    opcode_lui,
                    opcode_jal:    next_state = st_writeback;
                    opcode_auipc,
                    opcode_jalr,
                    opcode_op_imm,
                    opcode_op:     next_state = st_execute;
                    opcode_branch: next_state = st_branch;
                    opcode_load,
                    opcode_store:  next_state = st_mem_addr;
                    // ebreak, other system codes and anything unknown
                    default:       next_state = st_halt;
                endcase
            end
            st_execute:   next_state = st_writeback;
            st_mem_addr:  next_state = (status.opcode == opcode_load) ? st_mem_read
                                                                      : st_mem_write;
            st_mem_read:  next_state = st_writeback;
            st_mem_write: next_state = st_fetch;
            st_writeback: next_state = st_fetch;
            st_branch:    next_state = st_fetch;
            default:      next_state = st_halt;
        endcase
    end

    assign is_op = (status.opcode == opcode_op);

    // funct7 bit 5 picks sub only for register ops, sra for both
    always_comb begin
        case (status.funct3)
            3'b000:  op_fn = (is_op && status.funct7[5]) ? alu_sub : alu_add;
            3'b001:  op_fn = alu_sll;
            3'b010:  op_fn = alu_slt;
            3'b011:  op_fn = alu_sltu;
            3'b100:  op_fn = alu_xor;
            3'b101:  op_fn = status.funct7[5] ? alu_sra : alu_srl;
            3'b110:  op_fn = alu_or;
            default: op_fn = alu_and;
        endcase
    end

    always_comb begin
        case (status.funct3)
            3'b001:  branch_fn = alu_ne;
            3'b100:  branch_fn = alu_lt;
            3'b101:  branch_fn = alu_ge;
            3'b110:  branch_fn = alu_ltu;
            3'b111:  branch_fn = alu_geu;
            default: branch_fn = alu_eq;
        endcase
    end

    always_comb begin
        ctrl = '{alu_fn: alu_add, opa_sel: opa_rs1, opb_sel: opb_rs2,
                 wb_sel: wb_alu_out, default: 1'b0};
        case (state)
            st_fetch: begin
                ctrl.opa_sel    = opa_pc;
                ctrl.opb_sel    = opb_four;
                ctrl.pc_we      = 1'b1;
                ctrl.last_pc_we = 1'b1;
                ctrl.inst_we    = 1'b1;
            end
            // branch and jal target, last_pc + imm
            st_decode: begin
                ctrl.opa_sel    = opa_last_pc;
                ctrl.opb_sel    = opb_imm;
                ctrl.alu_out_we = 1'b1;
            end
            st_execute: begin
                ctrl.alu_out_we = 1'b1;
                case (status.opcode)
                    opcode_op: ctrl.alu_fn = op_fn;
                    opcode_op_imm: begin
                        ctrl.alu_fn  = op_fn;
                        ctrl.opb_sel = opb_imm;
                    end
                    opcode_auipc: begin
                        ctrl.opa_sel = opa_last_pc;
                        ctrl.opb_sel = opb_imm;
                    end
                    default: ctrl.opb_sel = opb_imm;
                endcase
            end
            st_mem_addr: begin
                ctrl.opb_sel    = opb_imm;
                ctrl.alu_out_we = 1'b1;
            end
            st_mem_read: begin
                ctrl.addr_sel = 1'b1;
                ctrl.data_we  = 1'b1;
            end
            st_mem_write: ctrl.addr_sel = 1'b1;
            st_writeback: begin
                ctrl.rf_we = 1'b1;
                case (status.opcode)
                    opcode_lui:  ctrl.wb_sel = wb_imm;
                    opcode_load: ctrl.wb_sel = wb_data;
                    opcode_jal: begin
                        ctrl.wb_sel      = wb_pc;
                        ctrl.pc_we       = 1'b1;
                        ctrl.next_pc_sel = 1'b1;
                    end
                    // link from pc, target rs1 + imm straight from the alu
                    opcode_jalr: begin
                        ctrl.wb_sel  = wb_pc;
                        ctrl.opb_sel = opb_imm;
                        ctrl.pc_we   = 1'b1;
                    end
                    default: ctrl.wb_sel = wb_alu_out;
                endcase
            end
            st_branch: begin
                ctrl.alu_fn      = branch_fn;
                ctrl.next_pc_sel = 1'b1;
                ctrl.pc_we       = status.alu_zero;
            end
            default: begin
            end
        endcase
    end

    assign mem_write = (state == st_mem_write);
    assign halt      = (state == st_halt);

    a_no_rf_and_store: assert property (
        @(posedge clock) disable iff (!arst_n) !(ctrl.rf_we && mem_write)
    ) else $error("register write and store in the same cycle");

    a_halt_sticky: assert property (
        @(posedge clock) disable iff (!arst_n) halt |=> halt
    ) else $error("halt dropped without reset");

endmodule

// ==== hw/simple_mc_top.sv ====
// RV32I multicycle core top
// control and datapath joined, one word-wide memory port
`timescale 1ns/1ps

module simple_mc_top (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic [rv_pkg::xlen-1:0] mem_read_data,
    output logic [rv_pkg::xlen-1:0] mem_address,
    output logic [rv_pkg::xlen-1:0] mem_write_data,
    output logic                    mem_write,
    output logic                    halt,
    output logic [rv_pkg::xlen-1:0] pc
);
    import rv_pkg::*;

    dp_ctrl_t     ctrl;
    inst_fields_t status;

    multicycle_control control0 (
        .clock     (clock),
        .arst_n    (arst_n),
        .status    (status),
        .ctrl      (ctrl),
        .mem_write (mem_write),
        .halt      (halt)
    );

    multicycle_datapath datapath0 (
        .clock          (clock),
        .arst_n         (arst_n),
        .ctrl           (ctrl),
        .mem_read_data  (mem_read_data),
        .mem_address    (mem_address),
        .mem_write_data (mem_write_data),
        .status         (status),
        .pc             (pc)
    );

endmodule

// ==== include/tb_program.svh ====
// test program for the multicycle core testbench
// program image, data-area layout and the expected store slots in order
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int program_len = 63;
localparam int store_len   = 22;

// operands A and B live here, results go from store_base upward
localparam logic [31:0] data_a_addr = 32'h0000_0200;
localparam logic [31:0] data_b_addr = 32'h0000_0204;
localparam logic [31:0] store_base  = 32'h0000_0300;

// constants and instruction addresses used by the program
localparam int          addi_imm    = -1234;
localparam logic [19:0] lui_upper   = 20'habcde;
localparam logic [19:0] auipc_upper = 20'h12345;
localparam logic [31:0] auipc_addr  = 32'd112;
localparam logic [31:0] jal_addr    = 32'd120;
localparam logic [31:0] jalr_addr   = 32'd132;
localparam logic [31:0] ebreak_addr = 32'd248;

typedef enum logic [4:0] {
    tag_add, tag_sub, tag_and, tag_or, tag_xor,
    tag_slt, tag_sltu, tag_sll, tag_srl, tag_sra,
    tag_addi, tag_lui, tag_auipc, tag_jal, tag_jalr,
    tag_beq, tag_bne, tag_blt, tag_bge, tag_bltu, tag_bgeu,
    tag_reload
} store_tag_e;

typedef struct packed {
    logic [31:0] addr;
    store_tag_e  tag;
} store_slot_t;

// x1 data base, x4 store base, x2 = A, x3 = B, x5 result, x8 branch flag
localparam logic [31:0] program_words [0:program_len-1] = '{
    32'h20000093, 32'h30000213,  // addi x1, x0, 0x200 ; addi x4, x0, 0x300
    32'h0000a103, 32'h0040a183,  // lw x2, 0(x1) ; lw x3, 4(x1)
    32'h003102b3, 32'h00522023,  // add ; sw 0(x4)
    32'h403102b3, 32'h00522223,  // sub ; sw 4(x4)
    32'h003172b3, 32'h00522423,  // and ; sw 8(x4)
    32'h003162b3, 32'h00522623,  // or ; sw 12(x4)
    32'h003142b3, 32'h00522823,  // xor ; sw 16(x4)
    32'h003122b3, 32'h00522a23,  // slt ; sw 20(x4)
    32'h003132b3, 32'h00522c23,  // sltu ; sw 24(x4)
    32'h003112b3, 32'h00522e23,  // sll ; sw 28(x4)
    32'h003152b3, 32'h02522023,  // srl ; sw 32(x4)
    32'h403152b3, 32'h02522223,  // sra ; sw 36(x4)
    32'hb2e10293, 32'h02522423,  // addi x5, x2, -1234 ; sw 40(x4)
    32'habcde2b7, 32'h02522623,  // lui x5, 0xabcde ; sw 44(x4)
    32'h12345297, 32'h02522823,  // auipc x5, 0x12345 ; sw 48(x4)
    32'h0080036f, 32'h00100073, 32'h02622a23,  // jal x6, +8 ; ebreak ; sw x6, 52(x4)
    32'h08d003e7, 32'h00100073, 32'h02722c23,  // jalr x7, 141(x0) ; ebreak ; sw x7, 56
    // each line: x8 = 1, branch +8 past the clear, x8 = 0, store x8
    32'h00100413, 32'h00310463, 32'h00000413, 32'h02822e23,  // beq, 60(x4)
    32'h00100413, 32'h00311463, 32'h00000413, 32'h04822023,  // bne, 64(x4)
    32'h00100413, 32'h00314463, 32'h00000413, 32'h04822223,  // blt, 68(x4)
    32'h00100413, 32'h00315463, 32'h00000413, 32'h04822423,  // bge, 72(x4)
    32'h00100413, 32'h00316463, 32'h00000413, 32'h04822623,  // bltu, 76(x4)
    32'h00100413, 32'h00317463, 32'h00000413, 32'h04822823,  // bgeu, 80(x4)
    32'h00022503, 32'h04a22a23,  // lw x10, 0(x4) ; sw x10, 84(x4)
    32'h00100073                 // ebreak
};

localparam store_slot_t store_table [0:store_len-1] = '{
    '{32'h300, tag_add},   '{32'h304, tag_sub},
    '{32'h308, tag_and},   '{32'h30c, tag_or},
    '{32'h310, tag_xor},   '{32'h314, tag_slt},
    '{32'h318, tag_sltu},  '{32'h31c, tag_sll},
    '{32'h320, tag_srl},   '{32'h324, tag_sra},
    '{32'h328, tag_addi},  '{32'h32c, tag_lui},
    '{32'h330, tag_auipc}, '{32'h334, tag_jal},
    '{32'h338, tag_jalr},  '{32'h33c, tag_beq},
    '{32'h340, tag_bne},   '{32'h344, tag_blt},
    '{32'h348, tag_bge},   '{32'h34c, tag_bltu},
    '{32'h350, tag_bgeu},  '{32'h354, tag_reload}
};

`endif

// ==== sim/tb_simple_mc.sv ====
// testbench for the RV32I multicycle core
// runs the test program on random operands and checks every store against ISA rules
`timescale 1ns/1ps

module tb_simple_mc;
    import rv_pkg::*;

    `include "tb_program.svh"

    localparam int          clock_period     = 10;
    localparam int          reset_cycles     = 4;
    localparam int          rounds           = 4;
    localparam int          cycles_per_round = 400;
    localparam int          timeout_ns       = rounds * cycles_per_round * clock_period;
    localparam int          mem_words        = 256;
    localparam logic [15:0] lfsr_seed        = 16'd14910;

    logic            clock;
    logic            arst_n;
    logic [xlen-1:0] mem_read_data;
    logic [xlen-1:0] mem_address;
    logic [xlen-1:0] mem_write_data;
    logic            mem_write;
    logic            halt;
    logic [xlen-1:0] pc;

    logic [31:0] mem [0:mem_words-1];
    logic [15:0] lfsr;
    logic [31:0] operand_a;
    logic [31:0] operand_b;
    int          store_count;
    int          stores_checked;
    int          errors;

    simple_mc_top dut0 (
        .clock          (clock),
        .arst_n         (arst_n),
        .mem_read_data  (mem_read_data),
        .mem_address    (mem_address),
        .mem_write_data (mem_write_data),
        .mem_write      (mem_write),
        .halt           (halt),
        .pc             (pc)
    );

    always #(clock_period / 2) clock = ~clock;

    // word memory, combinational read
    assign mem_read_data = mem[mem_address[9:2]];

    // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 16'hb400;
        end
        return next;
    endfunction

    task automatic draw_word(output logic [31:0] word);
        word = '0;
        for (int i = 0; i < 32; i++) begin
            word = {word[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // two's complement order: differing signs decide, else the unsigned order
    function automatic logic signed_less(logic [31:0] a, logic [31:0] b);
        return (a[31] != b[31]) ? a[31] : (a < b);
    endfunction

    function automatic logic [31:0] expected_value(store_tag_e tag, logic [31:0] a,
                                                   logic [31:0] b);
        logic [31:0] value;
        case (tag)
            tag_add, tag_reload: value = a + b;
            tag_sub:   value = a - b;
            tag_and:   value = a & b;
            tag_or:    value = a | b;
            tag_xor:   value = a ^ b;
            tag_slt:   value = {31'b0, signed_less(a, b)};
            tag_sltu:  value = {31'b0, a < b};
            tag_sll:   value = a << b[4:0];
            tag_srl:   value = a >> b[4:0];
            // vacated upper bits filled with the sign
            tag_sra:   value = (a >> b[4:0]) |
                               (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0);
            tag_addi:  value = a + 32'(addi_imm);
            tag_lui:   value = {lui_upper, 12'b0};
            tag_auipc: value = auipc_addr + {auipc_upper, 12'b0};
            // links point past the jump
            tag_jal:   value = jal_addr + 32'd4;
            tag_jalr:  value = jalr_addr + 32'd4;
            tag_beq:   value = {31'b0, a == b};
            tag_bne:   value = {31'b0, a != b};
            tag_blt:   value = {31'b0, signed_less(a, b)};
            tag_bge:   value = {31'b0, !signed_less(a, b)};
            tag_bltu:  value = {31'b0, a < b};
            tag_bgeu:  value = {31'b0, a >= b};
            default:   value = '0;
        endcase
        return value;
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("MISMATCH at %0d ns: %s got %h expected %h", $time, name, got,
                     expected);
        end
    endtask

    task automatic load_round_memory();
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = 32'hdead_0000 | 32'(i);
        end
        for (int i = 0; i < program_len; i++) begin
            mem[i] = program_words[i];
        end
        draw_word(operand_a);
        draw_word(operand_b);
        mem[data_a_addr[9:2]] = operand_a;
        mem[data_b_addr[9:2]] = operand_b;
    endtask

    // memory write port and store checker
    always @(posedge clock) begin
        if (mem_write) begin
            mem[mem_address[9:2]] <= mem_write_data;
            if (!arst_n) begin
                errors++;
                $display("store to %h while reset was asserted, at %0d ns", mem_address,
                         $time);
            end else if (store_count >= store_len) begin
                errors++;
                $display("unexpected extra store to %h at %0d ns", mem_address, $time);
            end else begin
                check_value("mem_address", mem_address, store_table[store_count].addr);
                check_value("mem_write_data", mem_write_data,
                            expected_value(store_table[store_count].tag, operand_a,
                                           operand_b));
                store_count <= store_count + 1;
            end
        end else if (!arst_n) begin
            store_count <= 0;
        end
    end

    initial begin
        #(timeout_ns);
        $display("timeout: the core did not finish %0d rounds within %0d ns", rounds,
                 timeout_ns);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        clock          = 1'b0;
        arst_n         = 1'b0;
        lfsr           = lfsr_seed;
        errors         = 0;
        stores_checked = 0;
        store_count    = 0;
        for (int round = 0; round < rounds; round++) begin
            // core is in reset or halted here, so nothing reads the memory
            load_round_memory();
            @(posedge clock);
            arst_n <= 1'b0;
            repeat (reset_cycles - 1) @(posedge clock);
            @(negedge clock);
            check_value("pc", pc, reset_pc);
            check_value("halt", 32'(halt), 32'd0);
            @(posedge clock);
            arst_n <= 1'b1;
            while (!halt) begin
                @(negedge clock);
            end
            check_value("pc", pc, ebreak_addr + 32'd4);
            check_value("store_count", 32'(store_count), 32'(store_len));
            // halted core must stay put
            repeat (8) @(negedge clock);
            check_value("halt", 32'(halt), 32'd1);
            check_value("pc", pc, ebreak_addr + 32'd4);
            check_value("store_count", 32'(store_count), 32'(store_len));
            stores_checked += store_count;
        end
        $display("errors: %0d, stores checked: %0d over %0d rounds", errors, stores_checked,
                 rounds);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== simple_mc.f ====
+incdir+include
hw/rv_pkg.sv
hw/rv_decode.sv
hw/rv_alu.sv
hw/rv_regfile.sv
hw/multicycle_datapath.sv
hw/multicycle_control.sv
hw/simple_mc_top.sv
sim/tb_simple_mc.sv

// ==== Makefile ====
# Verilator build and run for the simple_mc RV32I multicycle core

VERILATOR ?= verilator
TOP       ?= tb_simple_mc
FILELIST  ?= simple_mc.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(filter %.sv,$(shell cat $(FILELIST)))
HEADERS := $(wildcard include/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "SIMULATION FAILED" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
